//--- pps_timebase_settings.svh
`ifndef PPS_TIMEBASE_SETTINGS_SVH
`define PPS_TIMEBASE_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// register map
// ~~~~~~~~~~~~~~~~~~~~
`define PPS_CTRL_ADDR       8'h00
`define PPS_TRIM_ADDR       8'h04
`define PPS_SEC_ADDR        8'h08
`define PPS_LASTPPS_ADDR    8'h0C
`define PPS_LLASTPPS_ADDR   8'h10
`define PPS_LASTDEAD_ADDR   8'h14
`define PPS_LLASTDEAD_ADDR  8'h18
`define PPS_LASTPANIC_ADDR  8'h1C

// period is trim+1 cycles, kept short for simulation
`define PPS_TRIM_RESET      16'd999
// slack past one period before ext pps is dead
`define PPS_DEAD_MARGIN     16'd50

`define PPS_WB_ADR_W        8
`define PPS_WB_DAT_W        32

`endif

//--- pps_timebase_pkg.sv
package pps_timebase_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // time records
    // ~~~~~~~~~~~~~~~~~~~~

    // seconds count
    typedef logic [31:0] sec_t;

    // free-running cycle count at an event
    typedef logic [31:0] stamp_t;

    // dead event, seconds value when the ext pps went away
    typedef logic [31:0] dead_rec_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // source settings
    // ~~~~~~~~~~~~~~~~~~~~

    // period is trim+1 cycles
    typedef logic [15:0] trim_t;

    // cycles after an accepted edge where new edges are rejected
    typedef logic [15:0] holdoff_t;

endpackage

//--- pps_source_select.sv
`timescale 1ns/1ps
`include "pps_timebase_settings.svh"

module pps_source_select
    import pps_timebase_pkg::*;
(
    input  logic     sys_clk_i,
    input  logic     wb_rst_i,
    input  logic     ext_pps_i,
    input  logic     en_int_pps_i,
    input  logic     use_ext_pps_i,
    input  holdoff_t pps_holdoff_i,
    input  trim_t    pps_trim_i,
    input  logic     update_pps_trim_i,
    output trim_t    pps_trim_o,
    output logic     pps_pulse_o,
    output logic     panic_pulse_o,
    output logic     dead_pulse_o
);

    trim_t       trim_new;
    trim_t       trim_act;
    trim_t       period_cnt;
    holdoff_t    holdoff_cnt;
    logic [16:0] watch_cnt;
    logic        ext_q;
    logic        ext_d;
    logic        flywheel;
    logic        ext_edge;
    logic        accept;
    logic        reject;
    logic        wrap;
    logic        timeout;
    logic        int_pulse;
    logic        fly_pulse;
    logic        restart;

    assign ext_edge  = ext_q && !ext_d;
    assign accept    = use_ext_pps_i && ext_edge && (holdoff_cnt == '0);
    assign reject    = use_ext_pps_i && ext_edge && (holdoff_cnt != '0);
    assign wrap      = (period_cnt == trim_act);
    assign timeout   = use_ext_pps_i && !flywheel && !accept &&
                       (watch_cnt == {1'b0, trim_act} + {1'b0, `PPS_DEAD_MARGIN});
    assign int_pulse = en_int_pps_i && !use_ext_pps_i && wrap;
    assign fly_pulse = use_ext_pps_i && flywheel && wrap;
    // new period on wrap, accepted edge or loss of ext pps
    assign restart   = wrap || accept || timeout;

    assign pps_trim_o = trim_new;

    always_ff @(posedge sys_clk_i) begin
        if (wb_rst_i) begin
            ext_q         <= 1'b0;
            ext_d         <= 1'b0;
            trim_new      <= `PPS_TRIM_RESET;
            trim_act      <= `PPS_TRIM_RESET;
            period_cnt    <= '0;
            holdoff_cnt   <= '0;
            watch_cnt     <= '0;
            flywheel      <= 1'b0;
            pps_pulse_o   <= 1'b0;
            panic_pulse_o <= 1'b0;
            dead_pulse_o  <= 1'b0;
        end else begin
            ext_q <= ext_pps_i;
            ext_d <= ext_q;

            if (update_pps_trim_i)
                trim_new <= pps_trim_i;

            // ~~~~~~~~~~~~~~~~~~~~
            // period counter, trim only changes at a period start
            if (restart) begin
                period_cnt <= '0;
                trim_act   <= trim_new;
            end else begin
                period_cnt <= period_cnt + 16'd1;
            end

            // ~~~~~~~~~~~~~~~~~~~~
            // holdoff window after an accepted edge
            if (accept)
                holdoff_cnt <= pps_holdoff_i;
            else if (holdoff_cnt != '0)
                holdoff_cnt <= holdoff_cnt - 16'd1;

            // ~~~~~~~~~~~~~~~~~~~~
            // dead watch, one dead event per outage
            if (!use_ext_pps_i || accept) begin
                watch_cnt <= '0;
                flywheel  <= 1'b0;
            end else if (timeout) begin
                watch_cnt <= '0;
                flywheel  <= 1'b1;
            end else if (!flywheel) begin
                watch_cnt <= watch_cnt + 17'd1;
            end

            pps_pulse_o   <= int_pulse || accept || fly_pulse || timeout;
            panic_pulse_o <= reject;
            dead_pulse_o  <= timeout;
        end
    end

endmodule

//--- pps_second_counter.sv
`timescale 1ns/1ps

module pps_second_counter
    import pps_timebase_pkg::*;
(
    input  logic      sys_clk_i,
    input  logic      wb_rst_i,
    input  logic      pps_pulse_i,
    input  logic      panic_pulse_i,
    input  logic      dead_pulse_i,
    input  logic      load_sec_i,
    input  sec_t      update_sec_i,
    output sec_t      cur_sec_o,
    output logic      pps_stamp_strobe_o,
    output stamp_t    pps_stamp_o,
    output logic      dead_strobe_o,
    output dead_rec_t dead_rec_o,
    output logic      panic_strobe_o,
    output stamp_t    panic_stamp_o
);

    stamp_t cycle_cnt;

    // ~~~~~~~~~~~~~~~~~~~~
    // counters and strobes
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge sys_clk_i) begin
        if (wb_rst_i) begin
            cycle_cnt          <= '0;
            cur_sec_o          <= '0;
            pps_stamp_strobe_o <= 1'b0;
            dead_strobe_o      <= 1'b0;
            panic_strobe_o     <= 1'b0;
        end else begin
            cycle_cnt <= cycle_cnt + 32'd1;

            // a load wins over a pulse in the same cycle
            if (load_sec_i)
                cur_sec_o <= update_sec_i;
            else if (pps_pulse_i)
                cur_sec_o <= cur_sec_o + 32'd1;

            pps_stamp_strobe_o <= pps_pulse_i;
            dead_strobe_o      <= dead_pulse_i;
            panic_strobe_o     <= panic_pulse_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // event payloads
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge sys_clk_i) begin
        if (pps_pulse_i)
            pps_stamp_o <= cycle_cnt;
        // seconds value before this pulse is counted
        if (dead_pulse_i)
            dead_rec_o <= cur_sec_o;
        if (panic_pulse_i)
            panic_stamp_o <= cycle_cnt;
    end

endmodule

//--- pps_event_history.sv
`timescale 1ns/1ps

module pps_event_history
    import pps_timebase_pkg::*;
#(
    parameter type payload_t = stamp_t
) (
    input  logic     sys_clk_i,
    input  logic     wb_rst_i,
    input  logic     strobe_i,
    input  payload_t payload_i,
    output payload_t last_o,
    output payload_t llast_o
);

    // two-entry shift, newest in last_o
    always_ff @(posedge sys_clk_i) begin
        if (wb_rst_i) begin
            last_o  <= '0;
            llast_o <= '0;
        end else if (strobe_i) begin
            last_o  <= payload_i;
            llast_o <= last_o;
        end
    end

endmodule

//--- pps_time_register_core.sv
`timescale 1ns/1ps
`include "pps_timebase_settings.svh"

module pps_time_register_core
    import pps_timebase_pkg::*;
(
    input  logic                        sys_clk_i,
    input  logic                        wb_rst_i,
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [`PPS_WB_ADR_W-1:0]    wb_adr_i,
    input  logic [`PPS_WB_DAT_W/8-1:0]  wb_sel_i,
    input  logic [`PPS_WB_DAT_W-1:0]    wb_dat_i,
    output logic [`PPS_WB_DAT_W-1:0]    wb_dat_o,
    output logic                        wb_ack_o,
    input  trim_t                       pps_trim_i,
    input  sec_t                        cur_sec_i,
    input  stamp_t                      last_pps_i,
    input  stamp_t                      llast_pps_i,
    input  stamp_t                      last_panic_i,
    input  dead_rec_t                   last_dead_i,
    input  dead_rec_t                   llast_dead_i,
    output holdoff_t                    pps_holdoff_o,
    output logic                        en_int_pps_o,
    output logic                        use_ext_pps_o,
    output trim_t                       pps_trim_o,
    output logic                        update_pps_trim_o,
    output sec_t                        update_sec_o,
    output logic                        load_sec_o
);

    typedef enum logic [1:0] {
        IDLE,
        CAPTURE,
        ACK
    } state_t;

    state_t                     state;
    logic [`PPS_WB_DAT_W-1:0]   dat_reg;
    logic                       accept;
    logic                       capture_req;
    logic                       trim_wr;
    logic                       sec_wr;

    sec_t      cur_sec_hold;
    stamp_t    last_pps_hold;
    stamp_t    llast_pps_hold;
    stamp_t    last_panic_hold;
    dead_rec_t last_dead_hold;
    dead_rec_t llast_dead_hold;

    assign accept      = (state == IDLE) && wb_cyc_i && wb_stb_i;
    assign capture_req = accept && !wb_we_i && (wb_adr_i == `PPS_SEC_ADDR);
    assign trim_wr     = accept && wb_we_i && (wb_adr_i == `PPS_TRIM_ADDR);
    assign sec_wr      = accept && wb_we_i && (wb_adr_i == `PPS_SEC_ADDR);

    // ~~~~~~~~~~~~~~~~~~~~
    // snapshot, taken on a SEC read so later reads agree
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge sys_clk_i) begin
        if (capture_req) begin
            cur_sec_hold    <= cur_sec_i;
            last_pps_hold   <= last_pps_i;
            llast_pps_hold  <= llast_pps_i;
            last_panic_hold <= last_panic_i;
            last_dead_hold  <= last_dead_i;
            llast_dead_hold <= llast_dead_i;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // control register and stage strobes
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge sys_clk_i) begin
        if (wb_rst_i) begin
            en_int_pps_o      <= 1'b0;
            use_ext_pps_o     <= 1'b0;
            pps_holdoff_o     <= '0;
            update_pps_trim_o <= 1'b0;
            load_sec_o        <= 1'b0;
        end else begin
            if (state == ACK && wb_we_i && wb_adr_i == `PPS_CTRL_ADDR) begin
                if (wb_sel_i[0]) begin
                    en_int_pps_o  <= wb_dat_i[0];
                    use_ext_pps_o <= wb_dat_i[1];
                end
                if (wb_sel_i[2])
                    pps_holdoff_o[7:0] <= wb_dat_i[23:16];
                if (wb_sel_i[3])
                    pps_holdoff_o[15:8] <= wb_dat_i[31:24];
            end
            // data is in dat_reg when these fire
            update_pps_trim_o <= trim_wr;
            load_sec_o        <= sec_wr;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // bus FSM
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge sys_clk_i) begin
        if (wb_rst_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (wb_cyc_i && wb_stb_i) state <= wb_we_i ? ACK : CAPTURE;
                CAPTURE: state <= ACK;
                ACK:     state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // write data latched while idle, read data muxed in CAPTURE
    always_ff @(posedge sys_clk_i) begin
        if (state == IDLE) begin
            dat_reg <= wb_dat_i;
        end else if (state == CAPTURE) begin
            case (wb_adr_i)
                `PPS_CTRL_ADDR:
                    dat_reg <= {pps_holdoff_o, 14'd0, use_ext_pps_o, en_int_pps_o};
                `PPS_TRIM_ADDR:      dat_reg <= {16'd0, pps_trim_i};
                `PPS_SEC_ADDR:       dat_reg <= cur_sec_hold;
                `PPS_LASTPPS_ADDR:   dat_reg <= last_pps_hold;
                `PPS_LLASTPPS_ADDR:  dat_reg <= llast_pps_hold;
                `PPS_LASTDEAD_ADDR:  dat_reg <= last_dead_hold;
                `PPS_LLASTDEAD_ADDR: dat_reg <= llast_dead_hold;
                `PPS_LASTPANIC_ADDR: dat_reg <= last_panic_hold;
                default:             dat_reg <= dat_reg;
            endcase
        end
    end

    assign pps_trim_o   = dat_reg[15:0];
    assign update_sec_o = dat_reg;
    assign wb_dat_o     = dat_reg;
    assign wb_ack_o     = (state == ACK) && wb_cyc_i;

endmodule

//--- pps_timebase_top.sv
`timescale 1ns/1ps
`include "pps_timebase_settings.svh"

module pps_timebase_top
    import pps_timebase_pkg::*;
(
    input  logic                        sys_clk_i,
    input  logic                        wb_rst_i,
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [`PPS_WB_ADR_W-1:0]    wb_adr_i,
    input  logic [`PPS_WB_DAT_W/8-1:0]  wb_sel_i,
    input  logic [`PPS_WB_DAT_W-1:0]    wb_dat_i,
    output logic [`PPS_WB_DAT_W-1:0]    wb_dat_o,
    output logic                        wb_ack_o,
    input  logic                        ext_pps_i,
    output logic                        pps_o
);

    holdoff_t  pps_holdoff;
    logic      en_int_pps;
    logic      use_ext_pps;
    trim_t     trim_wr_data;
    trim_t     trim_cur;
    logic      update_pps_trim;
    sec_t      update_sec;
    logic      load_sec;
    logic      pps_pulse;
    logic      panic_pulse;
    logic      dead_pulse;
    sec_t      cur_sec;
    logic      pps_stamp_strobe;
    stamp_t    pps_stamp;
    logic      dead_strobe;
    dead_rec_t dead_rec;
    logic      panic_strobe;
    stamp_t    panic_stamp;
    stamp_t    last_pps;
    stamp_t    llast_pps;
    stamp_t    last_panic;
    dead_rec_t last_dead;
    dead_rec_t llast_dead;

    assign pps_o = pps_pulse;

    // ~~~~~~~~~~~~~~~~~~~~
    // pulse path
    // ~~~~~~~~~~~~~~~~~~~~
    pps_source_select u_pps_source_select (
        .sys_clk_i         (sys_clk_i),
        .wb_rst_i          (wb_rst_i),
        .ext_pps_i         (ext_pps_i),
        .en_int_pps_i      (en_int_pps),
        .use_ext_pps_i     (use_ext_pps),
        .pps_holdoff_i     (pps_holdoff),
        .pps_trim_i        (trim_wr_data),
        .update_pps_trim_i (update_pps_trim),
        .pps_trim_o        (trim_cur),
        .pps_pulse_o       (pps_pulse),
        .panic_pulse_o     (panic_pulse),
        .dead_pulse_o      (dead_pulse)
    );

    pps_second_counter u_pps_second_counter (
        .sys_clk_i          (sys_clk_i),
        .wb_rst_i           (wb_rst_i),
        .pps_pulse_i        (pps_pulse),
        .panic_pulse_i      (panic_pulse),
        .dead_pulse_i       (dead_pulse),
        .load_sec_i         (load_sec),
        .update_sec_i       (update_sec),
        .cur_sec_o          (cur_sec),
        .pps_stamp_strobe_o (pps_stamp_strobe),
        .pps_stamp_o        (pps_stamp),
        .dead_strobe_o      (dead_strobe),
        .dead_rec_o         (dead_rec),
        .panic_strobe_o     (panic_strobe),
        .panic_stamp_o      (panic_stamp)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // histories
    // ~~~~~~~~~~~~~~~~~~~~
    pps_event_history #(.payload_t(stamp_t)) u_pps_history (
        .sys_clk_i (sys_clk_i),
        .wb_rst_i  (wb_rst_i),
        .strobe_i  (pps_stamp_strobe),
        .payload_i (pps_stamp),
        .last_o    (last_pps),
        .llast_o   (llast_pps)
    );

    pps_event_history #(.payload_t(dead_rec_t)) u_dead_history (
        .sys_clk_i (sys_clk_i),
        .wb_rst_i  (wb_rst_i),
        .strobe_i  (dead_strobe),
        .payload_i (dead_rec),
        .last_o    (last_dead),
        .llast_o   (llast_dead)
    );

    // only the newest panic is mapped
    pps_event_history #(.payload_t(stamp_t)) u_panic_history (
        .sys_clk_i (sys_clk_i),
        .wb_rst_i  (wb_rst_i),
        .strobe_i  (panic_strobe),
        .payload_i (panic_stamp),
        .last_o    (last_panic),
        .llast_o   ()
    );

    pps_time_register_core u_pps_time_register_core (
        .sys_clk_i         (sys_clk_i),
        .wb_rst_i          (wb_rst_i),
        .wb_cyc_i          (wb_cyc_i),
        .wb_stb_i          (wb_stb_i),
        .wb_we_i           (wb_we_i),
        .wb_adr_i          (wb_adr_i),
        .wb_sel_i          (wb_sel_i),
        .wb_dat_i          (wb_dat_i),
        .wb_dat_o          (wb_dat_o),
        .wb_ack_o          (wb_ack_o),
        .pps_trim_i        (trim_cur),
        .cur_sec_i         (cur_sec),
        .last_pps_i        (last_pps),
        .llast_pps_i       (llast_pps),
        .last_panic_i      (last_panic),
        .last_dead_i       (last_dead),
        .llast_dead_i      (llast_dead),
        .pps_holdoff_o     (pps_holdoff),
        .en_int_pps_o      (en_int_pps),
        .use_ext_pps_o     (use_ext_pps),
        .pps_trim_o        (trim_wr_data),
        .update_pps_trim_o (update_pps_trim),
        .update_sec_o      (update_sec),
        .load_sec_o        (load_sec)
    );

endmodule

//--- tb_pps_timebase.sv
`timescale 1ns/1ps
`include "pps_timebase_settings.svh"

module tb_pps_timebase;

    logic        sys_clk_i;
    logic        wb_rst_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [7:0]  wb_adr_i;
    logic [3:0]  wb_sel_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        ext_pps_i;
    logic        pps_o;

    int          err_cnt = 0;
    int          timeout_cnt = 0;
    int          check_cnt = 0;
    logic [31:0] lfsr = 32'hbb9a;
    int          cycle = 0;
    int          pulse_cnt = 0;
    int          last_t = 0;
    int          prev_t = 0;
    int          read_pulses = 0;
    int          write_pulses = 0;
    int          last_rise = 0;

    pps_timebase_top u_pps_timebase_top (
        .sys_clk_i (sys_clk_i),
        .wb_rst_i  (wb_rst_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_sel_i  (wb_sel_i),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .ext_pps_i (ext_pps_i),
        .pps_o     (pps_o)
    );

    initial begin
        sys_clk_i = 1'b0;
        forever #10 sys_clk_i = ~sys_clk_i;
    end

    // cycles of the last two pps_o pulses
    always @(posedge sys_clk_i) begin
        cycle <= cycle + 1;
        if (pps_o) begin
            pulse_cnt <= pulse_cnt + 1;
            prev_t    <= last_t;
            last_t    <= cycle;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~
    function logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    task check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        assert (act === exp) else begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task wb_write(input logic [7:0] adr, input logic [31:0] dat, input logic [3:0] sel);
        int   waited;
        logic got;
        waited = 0;
        got = 1'b0;
        @(posedge sys_clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b1;
        wb_adr_i <= adr;
        wb_sel_i <= sel;
        wb_dat_i <= dat;
        while (!got && waited < 20) begin
            @(negedge sys_clk_i);
            waited++;
            got = wb_ack_o;
        end
        if (!got) begin
            $display("timeout waiting for the write ack at address %h", adr);
            timeout_cnt++;
        end else begin
            check_eq("wb_ack_o write latency", 2, waited);
        end
        @(posedge sys_clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        @(negedge sys_clk_i);
        // a load lands on this edge and wins over a pulse
        write_pulses = pulse_cnt;
        check_eq("wb_ack_o after write", 0, {31'd0, wb_ack_o});
    endtask

    task wb_read(input logic [7:0] adr, output logic [31:0] dat);
        int   waited;
        logic got;
        waited = 0;
        got = 1'b0;
        dat = '0;
        @(posedge sys_clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b0;
        wb_adr_i <= adr;
        wb_sel_i <= 4'hf;
        while (!got && waited < 20) begin
            @(negedge sys_clk_i);
            waited++;
            got = wb_ack_o;
            // pulses counted before the snapshot edge
            if (waited == 1)
                read_pulses = pulse_cnt;
        end
        if (!got) begin
            $display("timeout waiting for the read ack at address %h", adr);
            timeout_cnt++;
        end else begin
            check_eq("wb_ack_o read latency", 3, waited);
            dat = wb_dat_o;
        end
        @(posedge sys_clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        @(negedge sys_clk_i);
        check_eq("wb_ack_o after read", 0, {31'd0, wb_ack_o});
    endtask

    task wait_pulses(input int n, input int limit);
        int target;
        int waited;
        target = pulse_cnt + n;
        waited = 0;
        while (pulse_cnt < target && waited < limit) begin
            @(negedge sys_clk_i);
            waited++;
        end
        if (pulse_cnt < target) begin
            $display("timeout waiting for %0d pps_o pulses", n);
            timeout_cnt++;
        end
    endtask

    // external edge gap cycles after the last regular one
    task ext_pulse(input int gap, input bit regular);
        int waited;
        int start;
        waited = 0;
        start = last_rise;
        do begin
            @(posedge sys_clk_i);
            waited++;
        end while (cycle < start + gap && waited < 2000);
        if (cycle < start + gap) begin
            $display("timeout scheduling the external pulse");
            timeout_cnt++;
        end
        ext_pps_i <= 1'b1;
        if (regular)
            last_rise = cycle;
        repeat (4) @(posedge sys_clk_i);
        ext_pps_i <= 1'b0;
    endtask

    function int jitter();
        return int'(rand_bits(3) % 32'd7) - 3;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [31:0] rd;
        logic [31:0] rd2;
        logic [31:0] d;
        logic [3:0]  sel;
        logic        m_en;
        logic        m_use;
        logic [15:0] m_hold;
        logic [31:0] s0;
        logic [31:0] s1;
        logic [31:0] s_stop;
        logic [31:0] dead1;
        logic [31:0] dead_exp;
        int          p0;
        int          p1;
        int          p_stop;

        wb_rst_i  = 1'b1;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        wb_adr_i  = '0;
        wb_sel_i  = '0;
        wb_dat_i  = '0;
        ext_pps_i = 1'b0;
        repeat (8) @(posedge sys_clk_i);
        wb_rst_i <= 1'b0;

        // reset values
        wb_read(`PPS_CTRL_ADDR, rd);
        check_eq("wb_dat_o CTRL", 0, rd);
        wb_read(`PPS_TRIM_ADDR, rd);
        check_eq("wb_dat_o TRIM", 32'd999, rd);

        // byte selects on CTRL
        m_en = 1'b0;
        m_use = 1'b0;
        m_hold = '0;
        repeat (3) begin
            d = rand_bits(32);
            sel = 4'(rand_bits(4));
            wb_write(`PPS_CTRL_ADDR, d, sel);
            if (sel[0]) begin
                m_en  = d[0];
                m_use = d[1];
            end
            if (sel[2])
                m_hold[7:0] = d[23:16];
            if (sel[3])
                m_hold[15:8] = d[31:24];
            wb_read(`PPS_CTRL_ADDR, rd);
            check_eq("wb_dat_o CTRL", {m_hold, 14'd0, m_use, m_en}, rd);
        end
        wb_write(`PPS_CTRL_ADDR, 32'd0, 4'hf);

        // internal pps at 500 cycles
        wb_write(`PPS_TRIM_ADDR, 32'd499, 4'hf);
        wb_read(`PPS_TRIM_ADDR, rd);
        check_eq("wb_dat_o TRIM", 32'd499, rd);
        wb_write(`PPS_CTRL_ADDR, 32'd1, 4'h1);
        wait_pulses(1, 1200);
        wb_read(`PPS_SEC_ADDR, s0);
        p0 = read_pulses;
        wait_pulses(3, 1700);
        check_eq("pps_o period", 500, last_t - prev_t);
        wb_read(`PPS_SEC_ADDR, s1);
        p1 = read_pulses;
        check_eq("wb_dat_o SEC delta", p1 - p0, s1 - s0);
        wb_read(`PPS_LASTPPS_ADDR, rd);
        wb_read(`PPS_LLASTPPS_ADDR, rd2);
        check_eq("wb_dat_o LASTPPS-LLASTPPS", 500, rd - rd2);

        // seconds load
        d = rand_bits(32);
        wb_write(`PPS_SEC_ADDR, d, 4'hf);
        p0 = write_pulses;
        wait_pulses(2, 1200);
        wb_read(`PPS_SEC_ADDR, rd);
        check_eq("wb_dat_o SEC after load", d + (read_pulses - p0), rd);

        // external pps with holdoff 200
        wb_write(`PPS_CTRL_ADDR, {16'd200, 16'h0002}, 4'b1101);
        wb_read(`PPS_SEC_ADDR, s0);
        p0 = read_pulses;
        last_rise = cycle;
        repeat (4) ext_pulse(500 + jitter(), 1'b1);
        wb_read(`PPS_SEC_ADDR, s1);
        p1 = read_pulses;
        check_eq("pps_o count ext", 4, p1 - p0);
        check_eq("wb_dat_o SEC delta ext", p1 - p0, s1 - s0);
        // edge inside holdoff
        ext_pulse(100, 1'b0);
        wb_read(`PPS_SEC_ADDR, rd);
        check_eq("wb_dat_o SEC after panic", s1, rd);
        wb_read(`PPS_LASTPANIC_ADDR, rd);
        wb_read(`PPS_LASTPPS_ADDR, rd2);
        check_eq("wb_dat_o LASTPANIC-LASTPPS", 100, rd - rd2);
        repeat (2) ext_pulse(500 + jitter(), 1'b1);
        wb_read(`PPS_SEC_ADDR, s_stop);
        p_stop = read_pulses;
        check_eq("wb_dat_o SEC delta ext", 2, s_stop - s1);

        // first outage
        wait_pulses(1, 800);
        check_eq("pps_o dead interval", 550, last_t - prev_t);
        dead1 = s_stop + (pulse_cnt - 1 - p_stop);
        wait_pulses(2, 1200);
        check_eq("pps_o flywheel period", 500, last_t - prev_t);
        wb_read(`PPS_SEC_ADDR, rd);
        check_eq("wb_dat_o SEC delta dead", read_pulses - p_stop, rd - s_stop);
        wb_read(`PPS_LASTDEAD_ADDR, rd);
        check_eq("wb_dat_o LASTDEAD", dead1, rd);

        // back on ext pps and then a second outage
        last_rise = cycle;
        ext_pulse(20, 1'b1);
        ext_pulse(500 + jitter(), 1'b1);
        wb_read(`PPS_SEC_ADDR, s_stop);
        p_stop = read_pulses;
        wait_pulses(1, 800);
        check_eq("pps_o dead interval", 550, last_t - prev_t);
        dead_exp = s_stop + (pulse_cnt - 1 - p_stop);
        wait_pulses(1, 700);
        check_eq("pps_o flywheel period", 500, last_t - prev_t);
        wb_read(`PPS_SEC_ADDR, rd);
        wb_read(`PPS_LASTDEAD_ADDR, rd);
        check_eq("wb_dat_o LASTDEAD", dead_exp, rd);
        wb_read(`PPS_LLASTDEAD_ADDR, rd);
        check_eq("wb_dat_o LLASTDEAD", dead1, rd);

        $display("checks %0d, errors %0d, timeouts %0d", check_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- pps_timebase.f
+incdir+.
pps_timebase_pkg.sv
pps_source_select.sv
pps_second_counter.sv
pps_event_history.sv
pps_time_register_core.sv
pps_timebase_top.sv
tb_pps_timebase.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_pps_timebase -f pps_timebase.f
	@out=$$(./obj_dir/Vtb_pps_timebase); echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
